/* unlockerPkg.sv */
`default_nettype none

package unlockerPkg;

    // four BCD-style digits, most significant digit first
    typedef logic [15:0] credentialT;

    typedef enum logic [2:0] {
        cmdLogin,
        cmdLock,
        cmdResetPassword,
        cmdAddUser,
        cmdChangePassword,
        cmdDeleteUser
    } cmdT;

    typedef enum logic [1:0] {
        roleAdmin,
        roleUser,
        roleGuest
    } roleT;

    typedef enum logic [2:0] {
        statusOk,
        statusRejected,  // count, lock state, flag, full table or unknown name
        statusDenied,    // role not allowed
        statusLoginFail,
        statusLockout
    } statusT;

    typedef enum logic [1:0] {
        opNone,
        opAppend,
        opSetPassword,
        opRemove
    } tableOpT;

    localparam int defaultMaxUsers    = 8;
    localparam int defaultMaxAttempts = 3;

    localparam credentialT defaultAdminName     = 16'h1234;
    localparam credentialT defaultAdminPassword = 16'h1234;

endpackage

`default_nettype wire

/* commandCapture.sv */
`timescale 1ns/10ps
`default_nettype none

module commandCapture (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          cmdValid,
    output logic                         cmdReady,
    input  wire unlockerPkg::cmdT        cmd,
    input  wire unlockerPkg::credentialT nameDigits,
    input  wire unlockerPkg::credentialT passwordDigits,
    input  wire [7:0]                    entryCount,
    input  wire                          guestSwitch,
    input  wire                          cmdDone,
    output logic                         capValid,
    output unlockerPkg::cmdT             capCmd,
    output unlockerPkg::credentialT      capName,
    output unlockerPkg::credentialT      capPassword,
    output logic                         capCountOk,
    output logic                         capGuest
);
    import unlockerPkg::*;

    logic accept;
    logic countOk;

    assign accept = cmdValid && cmdReady;

    // digit count rule per command
    always_comb
    begin
        case (cmd)
            cmdLogin, cmdAddUser, cmdChangePassword:
                countOk = (entryCount == 8'd8);
            cmdDeleteUser:
                countOk = (entryCount == 8'd4);
            cmdResetPassword:
                countOk = (entryCount >= 8'd4);
            default:
                countOk = 1'b1; // lock takes no digits
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cmdReady <= 1'b1;
            capValid <= 1'b0;
        end
        else
        begin
            capValid <= accept;
            if (accept)
            begin
                cmdReady <= 1'b0;
            end
            else if (cmdDone)
            begin
                cmdReady <= 1'b1; // reopen the cycle after done
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            capCmd      <= cmd;
            capName     <= nameDigits;
            capPassword <= passwordDigits;
            capCountOk  <= countOk;
            capGuest    <= guestSwitch;
        end
    end

endmodule

`default_nettype wire

/* credentialTable.sv */
`timescale 1ns/10ps
`default_nettype none

module credentialTable #(
    parameter int  maxUsers = unlockerPkg::defaultMaxUsers,
    localparam int idxW     = $clog2(maxUsers),
    localparam int cntW     = $clog2(maxUsers + 1)
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          capValid,
    input  wire unlockerPkg::cmdT        capCmd,
    input  wire unlockerPkg::credentialT capName,
    input  wire unlockerPkg::credentialT capPassword,
    input  wire                          capCountOk,
    input  wire                          capGuest,
    output logic                         lookValid,
    output unlockerPkg::cmdT             lookCmd,
    output unlockerPkg::credentialT      lookName,
    output unlockerPkg::credentialT      lookPassword,
    output logic                         lookCountOk,
    output logic                         lookGuest,
    output logic                         nameHit,
    output logic [idxW-1:0]              nameIndex,
    output logic                         loginHit,
    output logic [idxW-1:0]              loginIndex,
    output logic [cntW-1:0]              userCount,
    output logic [2*maxUsers-1:0]        indexRole,
    input  wire unlockerPkg::tableOpT    tableOp,
    input  wire [idxW-1:0]               opIndex,
    input  wire unlockerPkg::credentialT opName,
    input  wire unlockerPkg::credentialT opPassword,
    input  wire unlockerPkg::roleT       opRole
);
    import unlockerPkg::*;

    credentialT names [maxUsers];
    credentialT passwords [maxUsers];
    roleT       roles [maxUsers];

    logic [cntW-1:0] count;
    logic [idxW-1:0] lastIndex;

    logic            hitName;
    logic [idxW-1:0] idxName;
    logic            hitLogin;
    logic [idxW-1:0] idxLogin;

    assign lastIndex = idxW'(count - 1'b1);

    // parallel compare over valid slots, descending so the lowest match wins
    always_comb
    begin
        hitName  = 1'b0;
        idxName  = '0;
        hitLogin = 1'b0;
        idxLogin = '0;
        for (int i = maxUsers - 1; i >= 0; i--)
        begin
            if (cntW'(i) < count && names[i] == capName)
            begin
                hitName = 1'b1;
                idxName = idxW'(i);
                if (passwords[i] == capPassword)
                begin
                    hitLogin = 1'b1;
                    idxLogin = idxW'(i);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookValid <= 1'b0;
        end
        else
        begin
            lookValid <= capValid;
        end
    end

    always_ff @(posedge clk)
    begin
        lookCmd      <= capCmd;
        lookName     <= capName;
        lookPassword <= capPassword;
        lookCountOk  <= capCountOk;
        lookGuest    <= capGuest;
        nameHit      <= hitName;
        nameIndex    <= idxName;
        loginHit     <= hitLogin;
        loginIndex   <= idxLogin;
        userCount    <= count;
        for (int i = 0; i < maxUsers; i++)
        begin
            indexRole[2*i +: 2] <= roles[i];
        end
    end

    // writes from the session stage land one edge after done
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count        <= cntW'(1);
            names[0]     <= defaultAdminName;
            passwords[0] <= defaultAdminPassword;
            roles[0]     <= roleAdmin;
        end
        else
        begin
            case (tableOp)
                opAppend:
                begin
                    names[idxW'(count)]     <= opName;
                    passwords[idxW'(count)] <= opPassword;
                    roles[idxW'(count)]     <= opRole;
                    count                   <= count + 1'b1;
                end
                opSetPassword:
                begin
                    passwords[opIndex] <= opPassword;
                end
                opRemove:
                begin
                    // last valid entry fills the hole
                    names[opIndex]     <= names[lastIndex];
                    passwords[opIndex] <= passwords[lastIndex];
                    roles[opIndex]     <= roles[lastIndex];
                    count              <= count - 1'b1;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* sessionControl.sv */
`timescale 1ns/10ps
`default_nettype none

module sessionControl #(
    parameter int  maxUsers    = unlockerPkg::defaultMaxUsers,
    parameter int  maxAttempts = unlockerPkg::defaultMaxAttempts,
    localparam int idxW        = $clog2(maxUsers),
    localparam int cntW        = $clog2(maxUsers + 1)
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          lookValid,
    input  wire unlockerPkg::cmdT        lookCmd,
    input  wire unlockerPkg::credentialT lookName,
    input  wire unlockerPkg::credentialT lookPassword,
    input  wire                          lookCountOk,
    input  wire                          lookGuest,
    input  wire                          nameHit,
    input  wire [idxW-1:0]               nameIndex,
    input  wire                          loginHit,
    input  wire [idxW-1:0]               loginIndex,
    input  wire [cntW-1:0]               userCount,
    input  wire [2*maxUsers-1:0]         indexRole,
    input  wire                          flagResolve,
    output logic                         locked,
    output logic                         flag,
    output logic                         flagSelect,
    output unlockerPkg::roleT            currentRole,
    output logic                         done,
    output unlockerPkg::statusT          status,
    output logic                         cmdDone,
    output unlockerPkg::tableOpT         tableOp,
    output logic [idxW-1:0]              opIndex,
    output unlockerPkg::credentialT      opName,
    output unlockerPkg::credentialT      opPassword,
    output unlockerPkg::roleT            opRole
);
    import unlockerPkg::*;

    localparam int attW = $clog2(maxAttempts + 1);

    logic [idxW-1:0] currentIndex;
    logic [attW-1:0] attempts;
    logic            isAdmin;

    assign isAdmin   = (currentRole == roleAdmin);
    assign cmdDone   = done;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            locked       <= 1'b1;
            flag         <= 1'b0;
            flagSelect   <= 1'b0;
            currentRole  <= roleAdmin;
            currentIndex <= '0;
            attempts     <= '0;
            done         <= 1'b0;
            status       <= statusOk;
            tableOp      <= opNone;
        end
        else
        begin
            done    <= lookValid;
            tableOp <= opNone;
            if (flagResolve)
            begin
                flag       <= 1'b0;
                flagSelect <= 1'b0;
            end
            if (lookValid)
            begin
                status <= statusRejected; // unless a case below accepts it
                if (!flag && lookCountOk)
                begin
                    case (lookCmd)
                        cmdLogin:
                        begin
                            if (locked && loginHit)
                            begin
                                locked       <= 1'b0;
                                currentIndex <= loginIndex;
                                currentRole  <= roleT'(indexRole[loginIndex*2 +: 2]);
                                attempts     <= '0;
                                status       <= statusOk;
                            end
                            else if (locked && attempts == attW'(maxAttempts - 1))
                            begin
                                attempts   <= '0;
                                flag       <= 1'b1;
                                flagSelect <= 1'b1;
                                status     <= statusLockout;
                            end
                            else if (locked)
                            begin
                                attempts   <= attempts + 1'b1;
                                flag       <= 1'b1;
                                flagSelect <= 1'b0;
                                status     <= statusLoginFail;
                            end
                        end
                        cmdLock:
                        begin
                            if (!locked)
                            begin
                                locked <= 1'b1;
                                status <= statusOk;
                                if (currentRole == roleGuest)
                                begin
                                    tableOp <= opRemove; // guests do not outlive the session
                                end
                            end
                        end
                        cmdResetPassword:
                        begin
                            if (!locked && currentRole == roleGuest)
                            begin
                                status <= statusDenied;
                            end
                            else if (!locked)
                            begin
                                tableOp <= opSetPassword;
                                status  <= statusOk;
                            end
                        end
                        cmdAddUser:
                        begin
                            if (!locked && !isAdmin)
                            begin
                                status <= statusDenied;
                            end
                            else if (!locked && userCount < cntW'(maxUsers))
                            begin
                                tableOp <= opAppend;
                                status  <= statusOk;
                            end
                        end
                        cmdChangePassword:
                        begin
                            if (!locked && !isAdmin)
                            begin
                                status <= statusDenied;
                            end
                            else if (!locked && nameHit)
                            begin
                                tableOp <= opSetPassword;
                                status  <= statusOk;
                            end
                        end
                        cmdDeleteUser:
                        begin
                            if (!locked && !isAdmin)
                            begin
                                status <= statusDenied;
                            end
                            else if (!locked && nameHit)
                            begin
                                tableOp <= opRemove;
                                status  <= statusOk;
                                if (nameIndex == currentIndex)
                                begin
                                    locked <= 1'b1; // admin removed itself
                                end
                            end
                        end
                        default:
                        begin
                        end
                    endcase
                end
            end
        end
    end

    // write payload that only matters alongside tableOp
    always_ff @(posedge clk)
    begin
        opName     <= lookName;
        opPassword <= lookPassword;
        opRole     <= lookGuest ? roleGuest : roleUser;
        if (lookCmd == cmdLock || lookCmd == cmdResetPassword)
        begin
            opIndex <= currentIndex;
        end
        else
        begin
            opIndex <= nameIndex;
        end
    end

endmodule

`default_nettype wire

/* unlocker.sv */
`timescale 1ns/10ps
`default_nettype none

module unlocker #(
    parameter int  maxUsers    = unlockerPkg::defaultMaxUsers,
    parameter int  maxAttempts = unlockerPkg::defaultMaxAttempts,
    localparam int idxW        = $clog2(maxUsers),
    localparam int cntW        = $clog2(maxUsers + 1)
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          cmdValid,
    output logic                         cmdReady,
    input  wire unlockerPkg::cmdT        cmd,
    input  wire unlockerPkg::credentialT nameDigits,
    input  wire unlockerPkg::credentialT passwordDigits,
    input  wire [7:0]                    entryCount,
    input  wire                          guestSwitch,
    input  wire                          flagResolve,
    output logic                         locked,
    output logic                         flag,
    output logic                         flagSelect,
    output unlockerPkg::roleT            currentRole,
    output logic                         done,
    output unlockerPkg::statusT          status
);
    import unlockerPkg::*;

    logic       capValid;
    cmdT        capCmd;
    credentialT capName;
    credentialT capPassword;
    logic       capCountOk;
    logic       capGuest;

    logic                  lookValid;
    cmdT                   lookCmd;
    credentialT            lookName;
    credentialT            lookPassword;
    logic                  lookCountOk;
    logic                  lookGuest;
    logic                  nameHit;
    logic [idxW-1:0]       nameIndex;
    logic                  loginHit;
    logic [idxW-1:0]       loginIndex;
    logic [cntW-1:0]       userCount;
    logic [2*maxUsers-1:0] indexRole;

    tableOpT         tableOp;
    logic [idxW-1:0] opIndex;
    credentialT      opName;
    credentialT      opPassword;
    roleT            opRole;
    logic            cmdDone;

    commandCapture i_commandCapture (
        .clk, .reset, .cmdValid, .cmdReady, .cmd, .nameDigits, .passwordDigits,
        .entryCount, .guestSwitch, .cmdDone, .capValid, .capCmd, .capName,
        .capPassword, .capCountOk, .capGuest
    );

    credentialTable #(
        .maxUsers (maxUsers)
    ) i_credentialTable (
        .clk, .reset, .capValid, .capCmd, .capName, .capPassword, .capCountOk,
        .capGuest, .lookValid, .lookCmd, .lookName, .lookPassword, .lookCountOk,
        .lookGuest, .nameHit, .nameIndex, .loginHit, .loginIndex, .userCount,
        .indexRole, .tableOp, .opIndex, .opName, .opPassword, .opRole
    );

    sessionControl #(
        .maxUsers    (maxUsers),
        .maxAttempts (maxAttempts)
    ) i_sessionControl (
        .clk, .reset, .lookValid, .lookCmd, .lookName, .lookPassword, .lookCountOk,
        .lookGuest, .nameHit, .nameIndex, .loginHit, .loginIndex, .userCount,
        .indexRole, .flagResolve, .locked, .flag, .flagSelect, .currentRole, .done,
        .status, .cmdDone, .tableOp, .opIndex, .opName, .opPassword, .opRole
    );

endmodule

`default_nettype wire

/* unlocker_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module unlockerAssertions (
    input wire clk,
    input wire reset,
    input wire cmdValid,
    input wire cmdReady,
    input wire done,
    input wire flag,
    input wire flagSelect
);

    logic accept;

    assign accept = cmdValid && cmdReady;

    // done is a single-cycle pulse
    doneSingle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held high for more than one cycle");

    doneLatency: assert property (@(posedge clk) disable iff (reset) accept |-> ##3 done)
        else $error("done did not follow acceptance by three cycles");

    // ready stays closed until the cycle after done
    readyClosed: assert property (@(posedge clk) disable iff (reset)
        accept |=> !cmdReady ##1 !cmdReady ##1 !cmdReady)
        else $error("cmdReady high while a command is in flight");

    flagPair: assert property (@(posedge clk) disable iff (reset) flagSelect |-> flag)
        else $error("flagSelect high without flag");

endmodule

bind unlocker unlockerAssertions i_assertions (
    .clk, .reset, .cmdValid, .cmdReady, .done, .flag, .flagSelect
);

`default_nettype wire

/* unlockerTb.sv */
`timescale 1ns/10ps
`default_nettype none

module unlockerTb;
    import unlockerPkg::*;

    localparam int timeoutCycles = 40;

    logic       clk;
    logic       reset;
    logic       cmdValid;
    logic       cmdReady;
    cmdT        cmd;
    credentialT nameDigits;
    credentialT passwordDigits;
    logic [7:0] entryCount;
    logic       guestSwitch;
    logic       flagResolve;
    logic       locked;
    logic       flag;
    logic       flagSelect;
    roleT       currentRole;
    logic       done;
    statusT     status;

    // live users besides the default admin
    credentialT userNames [$];
    credentialT userPasswords [$];
    roleT       userRoles [$];

    unlocker i_dut (
        .clk, .reset, .cmdValid, .cmdReady, .cmd, .nameDigits, .passwordDigits,
        .entryCount, .guestSwitch, .flagResolve, .locked, .flag, .flagSelect,
        .currentRole, .done, .status
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at %0t", $time);
    endtask

    task automatic checkStatus(input string name, input statusT actual, input statusT expected);
        if (actual !== expected)
            stopOnError($sformatf("Fail at %0t: %s expected %s, got %s", $time, name,
                                  expected.name(), actual.name()));
    endtask

    task automatic checkRole(input string name, input roleT actual, input roleT expected);
        if (actual !== expected)
            stopOnError($sformatf("Fail at %0t: %s expected %s, got %s", $time, name,
                                  expected.name(), actual.name()));
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            stopOnError($sformatf("Fail at %0t: %s expected %0b, got %0b", $time, name,
                                  expected, actual));
    endtask

    function automatic credentialT randomDigits();
        credentialT value;
        for (int i = 0; i < 4; i++)
        begin
            value[4*i +: 4] = 4'($urandom % 10); // decimal digits only
        end
        return value;
    endfunction

    function automatic credentialT freshName();
        credentialT candidate;
        logic       taken;
        do
        begin
            candidate = randomDigits();
            taken     = (candidate == defaultAdminName);
            foreach (userNames[i])
            begin
                if (userNames[i] == candidate)
                    taken = 1'b1;
            end
        end while (taken);
        return candidate;
    endfunction

    function automatic credentialT otherPassword(input credentialT old);
        credentialT candidate;
        do
        begin
            candidate = randomDigits();
        end while (candidate == old);
        return candidate;
    endfunction

    function automatic void removeUser(input int index);
        userNames.delete(index);
        userPasswords.delete(index);
        userRoles.delete(index);
    endfunction

    // called and returns on a falling edge
    task automatic issueCommand(input cmdT command, input credentialT name,
                                input credentialT password, input logic [7:0] count,
                                input logic guest, input statusT expected);
        int waited;
        waited = 0;
        while (!cmdReady)
        begin
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles)
                stopOnError("timeout: cmdReady stayed low");
        end
        cmdValid       = 1'b1;
        cmd            = command;
        nameDigits     = name;
        passwordDigits = password;
        entryCount     = count;
        guestSwitch    = guest;
        @(negedge clk);
        cmdValid = 1'b0;
        waited   = 0;
        while (!done)
        begin
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles)
                stopOnError("timeout: done never came after a command was accepted");
        end
        checkStatus($sformatf("status of %s", command.name()), status, expected);
    endtask

    task automatic login(input credentialT name, input credentialT password,
                         input statusT expected);
        issueCommand(cmdLogin, name, password, 8'd8, 1'b0, expected);
    endtask

    task automatic lockSession(input statusT expected);
        issueCommand(cmdLock, 16'h0000, 16'h0000, 8'd0, 1'b0, expected);
    endtask

    task automatic resolveFlag();
        flagResolve = 1'b1;
        @(negedge clk);
        flagResolve = 1'b0;
        checkBit("flag", flag, 1'b0);
        checkBit("flagSelect", flagSelect, 1'b0);
    endtask

    task automatic lockoutTest();
        login(defaultAdminName, 16'h9999, statusLoginFail);
        checkBit("flag", flag, 1'b1);
        checkBit("flagSelect", flagSelect, 1'b0);
        login(defaultAdminName, defaultAdminPassword, statusRejected); // flag still pending
        resolveFlag();
        login(defaultAdminName, 16'h4321, statusLoginFail);
        resolveFlag();
        login(defaultAdminName, 16'h0000, statusLockout);
        checkBit("flag", flag, 1'b1);
        checkBit("flagSelect", flagSelect, 1'b1);
        resolveFlag();
        checkBit("locked", locked, 1'b1);
    endtask

    task automatic addUserTest();
        credentialT name;
        credentialT password;
        login(defaultAdminName, defaultAdminPassword, statusOk);
        checkBit("locked", locked, 1'b0);
        checkRole("currentRole", currentRole, roleAdmin);
        for (int i = 0; i < defaultMaxUsers - 1; i++)
        begin
            name     = freshName();
            password = randomDigits();
            issueCommand(cmdAddUser, name, password, 8'd8, i[0], statusOk);
            userNames.push_back(name);
            userPasswords.push_back(password);
            userRoles.push_back(i[0] ? roleGuest : roleUser);
        end
        // table is full now
        issueCommand(cmdAddUser, freshName(), randomDigits(), 8'd8, 1'b0, statusRejected);
        lockSession(statusOk);
        checkBit("locked", locked, 1'b1);
        foreach (userNames[i])
        begin
            if (userRoles[i] == roleUser)
            begin
                login(userNames[i], userPasswords[i], statusOk);
                checkRole("currentRole", currentRole, roleUser);
                lockSession(statusOk);
            end
        end
    endtask

    task automatic passwordTest();
        credentialT changed;
        credentialT ownChoice;
        login(defaultAdminName, defaultAdminPassword, statusOk);
        changed = otherPassword(userPasswords[0]);
        issueCommand(cmdChangePassword, userNames[0], changed, 8'd8, 1'b0, statusOk);
        lockSession(statusOk);
        login(userNames[0], userPasswords[0], statusLoginFail);
        resolveFlag();
        userPasswords[0] = changed;
        login(userNames[0], changed, statusOk);
        checkRole("currentRole", currentRole, roleUser);
        ownChoice = otherPassword(changed);
        issueCommand(cmdResetPassword, userNames[0], ownChoice, 8'd4, 1'b0, statusOk);
        lockSession(statusOk);
        login(userNames[0], changed, statusLoginFail);
        resolveFlag();
        userPasswords[0] = ownChoice;
        login(userNames[0], ownChoice, statusOk);
        lockSession(statusOk);
    endtask

    task automatic deleteGuestTest();
        credentialT goneName;
        credentialT gonePassword;
        login(defaultAdminName, defaultAdminPassword, statusOk);
        goneName     = userNames[2];
        gonePassword = userPasswords[2];
        issueCommand(cmdDeleteUser, goneName, 16'h0000, 8'd4, 1'b0, statusOk);
        removeUser(2);
        lockSession(statusOk);
        login(goneName, gonePassword, statusLoginFail);
        resolveFlag();
        // walk from the back so a removal never shifts an unvisited entry
        for (int i = userNames.size() - 1; i >= 0; i--)
        begin
            login(userNames[i], userPasswords[i], statusOk);
            checkRole("currentRole", currentRole, userRoles[i]);
            lockSession(statusOk);
            if (userRoles[i] == roleGuest)
            begin
                login(userNames[i], userPasswords[i], statusLoginFail); // gone with the lock
                resolveFlag();
                removeUser(i);
            end
        end
    endtask

    task automatic ruleTest();
        credentialT guestName;
        credentialT guestPassword;
        login(defaultAdminName, defaultAdminPassword, statusOk);
        guestName     = freshName();
        guestPassword = randomDigits();
        issueCommand(cmdAddUser, guestName, guestPassword, 8'd8, 1'b1, statusOk);
        lockSession(statusOk);
        login(guestName, guestPassword, statusOk);
        checkRole("currentRole", currentRole, roleGuest);
        issueCommand(cmdResetPassword, guestName, randomDigits(), 8'd4, 1'b0, statusDenied);
        lockSession(statusOk);
        login(userNames[0], userPasswords[0], statusOk);
        issueCommand(cmdAddUser, freshName(), randomDigits(), 8'd8, 1'b0, statusDenied);
        issueCommand(cmdResetPassword, userNames[0], randomDigits(), 8'd3, 1'b0, statusRejected);
        login(userNames[0], userPasswords[0], statusRejected); // already unlocked
        lockSession(statusOk);
        lockSession(statusRejected);
        issueCommand(cmdLogin, defaultAdminName, defaultAdminPassword, 8'd7, 1'b0,
                     statusRejected);
        checkBit("locked", locked, 1'b1);
        checkBit("flag", flag, 1'b0);
    endtask

    initial
    begin
        void'($urandom(32'h5a0b_de36));
        reset          = 1'b1;
        cmdValid       = 1'b0;
        cmd            = cmdLogin;
        nameDigits     = 16'h0000;
        passwordDigits = 16'h0000;
        entryCount     = 8'd0;
        guestSwitch    = 1'b0;
        flagResolve    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkBit("locked", locked, 1'b1);
        checkBit("flag", flag, 1'b0);
        checkBit("flagSelect", flagSelect, 1'b0);
        checkBit("done", done, 1'b0);
        checkBit("cmdReady", cmdReady, 1'b1);
        checkRole("currentRole", currentRole, roleAdmin);
        lockoutTest();
        addUserTest();
        passwordTest();
        deleteGuestTest();
        ruleTest();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
unlockerPkg.sv
commandCapture.sv
credentialTable.sv
sessionControl.sv
unlocker.sv
unlocker_assertions.sv
unlockerTb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for the result
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/10ps -f sim.f \
    --top-module unlockerTb -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "sim passed" sim.log || { echo "FAILED: run ended early"; exit 1; }
echo "PASSED"
exit 0
